//--- exu.f
+incdir+source
source/exu_pkg.sv
source/exu_operand_sel.sv
source/exu_alu.sv
source/exu_ghr.sv
source/exu.sv
verif/exu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= exu_tb
RTL_TOP   ?= exu
FILELIST  ?= exu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/exu_tb.sv
`timescale 1ns/1ps
`include "exu_defines.svh"

module exu_tb;

   import exu_pkg::*;

   localparam int NUM_CYCLES      = 3000;
   localparam int WATCHDOG_CYCLES = 4000;

   logic                    clk = 1'b0;
   logic                    i_rst;
   logic                    i_x_ctl_en;
   logic                    i_alu_valid_d;
   exu_alu_op_t             i_op;
   logic [1:0]              i_rs1_bypass_en;
   logic [1:0]              i_rs2_bypass_en;
   exu_word_t               i_rs1_bypass_data;
   exu_word_t               i_rs2_bypass_data;
   exu_word_t               i_gpr_rs1;
   exu_word_t               i_gpr_rs2;
   logic                    i_rs1_en;
   logic                    i_rs2_en;
   logic                    i_select_pc;
   exu_pc_t                 i_pc_d;
   exu_word_t               i_immed;
   logic [`EXU_BRIMM_W-1:0] i_brimm;
   exu_predict_pkt_t        i_pp_d;
   logic                    i_flush_lower_r;
   exu_pc_t                 i_flush_path_r;
   exu_word_t               o_result_x;
   exu_pc_t                 o_pc_x;
   logic                    o_flush_final;
   exu_pc_t                 o_flush_path_final;
   exu_predict_pkt_t        o_mp_pkt;
   exu_ghr_t                o_mp_fghr;
   exu_ghr_t                o_ghr_x;

   // Reference state of the X stage and both histories
   logic                    m_valid_x;
   exu_alu_op_t             m_op_x;
   exu_predict_pkt_t        m_pp_x;
   exu_word_t               m_a_x;
   exu_word_t               m_b_x;
   exu_pc_t                 m_pc_x;
   logic [`EXU_BRIMM_W-1:0] m_brimm_x;
   exu_ghr_t                m_ghr_d;
   exu_ghr_t                m_ghr_x;
   logic                    m_data_known;      // X data flops loaded once

   int                      n_upper;
   int                      n_lower;
   int                      n_x_bypass;

   exu i_dut (.*);

   always #4 clk = ~clk;                        // 8 ns period

   task automatic report_mismatch(input string what, input string detail);
      $display("FAILED at time %0t: %s %s", $time, what, detail);
      $display("SOME TESTS FAILED");
      $fatal(1, "output mismatch");
   endtask

   task automatic compare_word(input string what, input exu_word_t got, input exu_word_t exp);
      if (got !== exp)
         report_mismatch(what, $sformatf("got %h expected %h", got, exp));
   endtask

   task automatic compare_pc(input string what, input exu_pc_t got, input exu_pc_t exp);
      if (got !== exp)
         report_mismatch(what, $sformatf("got %h expected %h", got, exp));
   endtask

   task automatic compare_pkt(input string what, input exu_predict_pkt_t got,
                              input exu_predict_pkt_t exp);
      if (got !== exp)
         report_mismatch(what, $sformatf("got %h expected %h", got, exp));
   endtask

   task automatic compare_ghr(input string what, input exu_ghr_t got, input exu_ghr_t exp);
      if (got !== exp)
         report_mismatch(what, $sformatf("got %b expected %b", got, exp));
   endtask

   task automatic compare_flag(input string what, input logic got, input logic exp);
      if (got !== exp)
         report_mismatch(what, $sformatf("got %b expected %b", got, exp));
   endtask

   function automatic logic is_branch_op(exu_alu_op_t op);
      return (op inside {br_beq, br_bne, br_blt, br_bge, br_jal});
   endfunction

   function automatic exu_word_t model_alu(exu_alu_op_t op, exu_word_t a, exu_word_t b);
      exu_word_t r;
      int        shamt;
      shamt = int'(b[4:0]);
      case (op)
         op_add:  r = a + b;
         op_sub:  r = a - b;
         op_and:  r = a & b;
         op_or:   r = a | b;
         op_xor:  r = a ^ b;
         op_slt:  r = (signed'(a) < signed'(b)) ? 32'd1 : 32'd0;
         op_sltu: r = (a < b) ? 32'd1 : 32'd0;
         op_sll:  r = a << shamt;
         op_srl:  r = a >> shamt;
         default: r = '0;
      endcase
      return r;
   endfunction

   function automatic logic model_taken(exu_alu_op_t op, exu_word_t a, exu_word_t b);
      case (op)
         br_beq:  return a == b;
         br_bne:  return a != b;
         br_blt:  return signed'(a) < signed'(b);
         br_bge:  return !(signed'(a) < signed'(b));
         br_jal:  return 1'b1;
         default: return 1'b0;
      endcase
   endfunction

   function automatic exu_word_t model_result();
      if (!m_valid_x)
         return '0;
      if (m_op_x == br_jal)
         return {m_pc_x + 31'd2, 1'b0};         // Link is PC plus 4 bytes
      if (is_branch_op(m_op_x))
         return '0;
      return model_alu(m_op_x, m_a_x, m_b_x);
   endfunction

   function automatic logic model_upper(logic lower);
      logic taken;
      taken = model_taken(m_op_x, m_a_x, m_b_x);
      return m_valid_x & is_branch_op(m_op_x) & ~lower &
             (taken != (m_pp_x.valid & m_pp_x.ataken));
   endfunction

   function automatic exu_pc_t model_path_x();
      int off;
      off = int'(signed'(m_brimm_x));
      if (model_taken(m_op_x, m_a_x, m_b_x))
         return m_pc_x + exu_pc_t'(off);
      return m_pc_x + 31'd2;
   endfunction

   function automatic exu_word_t model_rs1(exu_word_t res_x);
      if (i_rs1_bypass_en[0])
         return i_rs1_bypass_data;
      if (i_rs1_bypass_en[1])
         return res_x;
      if (i_select_pc)
         return {i_pc_d, 1'b0};
      if (i_rs1_en)
         return i_gpr_rs1;
      return '0;
   endfunction

   function automatic exu_word_t model_rs2(exu_word_t res_x);
      if (i_rs2_bypass_en[0])
         return i_rs2_bypass_data;
      if (i_rs2_bypass_en[1])
         return res_x;
      if (i_rs2_en)
         return i_gpr_rs2;
      return i_immed;
   endfunction

   function automatic logic [1:0] pick_bypass();
      case ($urandom_range(3, 0))
         1:       return 2'b01;
         2:       return 2'b10;
         default: return 2'b00;
      endcase
   endfunction

   // Small values often, so compares hit equal and near zero
   function automatic exu_word_t rand_word();
      if ($urandom_range(1, 0) == 0)
         return exu_word_t'($urandom_range(4, 0)) - 32'd2;
      return $urandom();
   endfunction

   task automatic drive_inputs();
      exu_predict_pkt_t pp;
      logic [3:0]       op_code;
      op_code           = 4'($urandom_range(13, 0));
      i_op              = exu_alu_op_t'(op_code);
      i_x_ctl_en        = ($urandom_range(7, 0) != 0);
      i_alu_valid_d     = ($urandom_range(9, 0) != 0);
      i_rs1_bypass_en   = pick_bypass();
      i_rs2_bypass_en   = pick_bypass();
      i_rs1_bypass_data = rand_word();
      i_rs2_bypass_data = rand_word();
      i_gpr_rs1         = rand_word();
      i_gpr_rs2         = rand_word();
      if ($urandom_range(3, 0) == 0)
         i_gpr_rs2 = i_gpr_rs1;                 // Equal operands for beq and bge
      i_rs1_en          = 1'($urandom());
      i_rs2_en          = 1'($urandom());
      i_select_pc       = ($urandom_range(3, 0) == 0);
      i_pc_d            = exu_pc_t'($urandom());
      i_immed           = rand_word();
      i_brimm           = 12'($urandom());
      pp.valid          = is_branch_op(i_op) & 1'($urandom());
      pp.ataken         = 1'($urandom());
      pp.misp           = 1'($urandom());
      pp.pc4            = 1'b1;
      pp.hist           = 2'($urandom());
      pp.toffset        = i_brimm;
      i_pp_d            = pp;
      i_flush_lower_r   = ($urandom_range(15, 0) == 0);
      i_flush_path_r    = exu_pc_t'($urandom());
      if (i_flush_lower_r)
         n_lower++;
   endtask

   // Next state at the coming rising edge from current state and inputs
   task automatic model_step();
      exu_word_t res_x;
      exu_word_t rs1;
      exu_word_t rs2;
      logic      act;
      res_x = model_result();
      rs1   = model_rs1(res_x);
      rs2   = model_rs2(res_x);
      act   = model_taken(m_op_x, m_a_x, m_b_x);
      if (m_valid_x && (i_rs1_bypass_en[1] || i_rs2_bypass_en[1]))
         n_x_bypass++;
      if (i_flush_lower_r)
         m_ghr_d = m_ghr_x;                     // Restore from resolved history
      else if (i_pp_d.valid && i_alu_valid_d)
         m_ghr_d = (m_ghr_d << 1) | exu_ghr_t'(i_pp_d.ataken);
      if (i_x_ctl_en)
      begin
         if (m_valid_x && m_pp_x.valid)
            m_ghr_x = (m_ghr_x << 1) | exu_ghr_t'(act);
         m_valid_x    = i_alu_valid_d & ~i_flush_lower_r;
         m_op_x       = i_op;
         m_pp_x       = i_pp_d;
         m_a_x        = rs1;
         m_b_x        = rs2;
         m_pc_x       = i_pc_d;
         m_brimm_x    = i_brimm;
         m_data_known = 1'b1;
      end
   endtask

   task automatic check_outputs();
      exu_predict_pkt_t exp_pkt;
      logic             upper;
      upper   = model_upper(i_flush_lower_r);
      exp_pkt = '0;
      if (upper)
      begin
         exp_pkt      = m_pp_x;
         exp_pkt.misp = 1'b1;
         n_upper++;
      end
      compare_word("o_result_x", o_result_x, model_result());
      if (m_data_known)
         compare_pc("o_pc_x", o_pc_x, m_pc_x);
      compare_flag("o_flush_final", o_flush_final, upper | i_flush_lower_r);
      if (i_flush_lower_r)
         compare_pc("o_flush_path_final", o_flush_path_final, i_flush_path_r);
      else if (m_data_known)
         compare_pc("o_flush_path_final", o_flush_path_final, model_path_x());
      compare_pkt("o_mp_pkt", o_mp_pkt, exp_pkt);
      compare_ghr("o_mp_fghr", o_mp_fghr, upper ? m_ghr_d : m_ghr_x);
      compare_ghr("o_ghr_x", o_ghr_x, m_ghr_x);
   endtask

   initial
   begin
      for (int t = 0; t < WATCHDOG_CYCLES; t++)
         @(posedge clk);
      $display("Run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
      $display("SOME TESTS FAILED");
      $fatal(1, "watchdog timeout");
   end

   initial
   begin
      int unsigned seed_val;
      seed_val          = $urandom(32'h7c6);
      i_rst             = 1'b1;
      i_x_ctl_en        = 1'b0;
      i_alu_valid_d     = 1'b0;
      i_op              = op_add;
      i_rs1_bypass_en   = '0;
      i_rs2_bypass_en   = '0;
      i_rs1_bypass_data = '0;
      i_rs2_bypass_data = '0;
      i_gpr_rs1         = '0;
      i_gpr_rs2         = '0;
      i_rs1_en          = 1'b0;
      i_rs2_en          = 1'b0;
      i_select_pc       = 1'b0;
      i_pc_d            = '0;
      i_immed           = '0;
      i_brimm           = '0;
      i_pp_d            = '0;
      i_flush_lower_r   = 1'b0;
      i_flush_path_r    = '0;
      m_valid_x         = 1'b0;
      m_op_x            = op_add;
      m_pp_x            = '0;
      m_ghr_d           = '0;
      m_ghr_x           = '0;
      m_data_known      = 1'b0;
      n_upper           = 0;
      n_lower           = 0;
      n_x_bypass        = 0;

      for (int n = 0; n < 2; n++)
         @(posedge clk);                        // Two reset cycles
      @(negedge clk);
      i_rst = 1'b0;

      // Reset values before any instruction
      compare_flag("o_flush_final", o_flush_final, 1'b0);
      compare_word("o_result_x", o_result_x, '0);
      compare_pkt("o_mp_pkt", o_mp_pkt, '0);
      compare_ghr("o_ghr_x", o_ghr_x, '0);

      for (int cyc = 0; cyc < NUM_CYCLES; cyc++)
      begin
         drive_inputs();
         model_step();
         @(negedge clk);
         check_outputs();
      end

      $display("Upper flushes %0d, lower flushes %0d, X bypasses %0d",
               n_upper, n_lower, n_x_bypass);
      if (n_upper > 0 && n_lower > 0 && n_x_bypass > 0)
      begin
         $display("ALL TESTS PASSED");
         $finish;
      end
      else
      begin
         $display("Random stimulus missed a flush or bypass case");
         $display("SOME TESTS FAILED");
         $fatal(1, "coverage hole");
      end
   end

endmodule

//--- source/exu.sv
`timescale 1ns/1ps
`include "exu_defines.svh"

module exu
(
   input  logic                      clk,
   input  logic                      i_rst,
   input  logic                      i_x_ctl_en,          // Advance D into X
   input  logic                      i_alu_valid_d,
   input  exu_pkg::exu_alu_op_t      i_op,
   input  logic [1:0]                i_rs1_bypass_en,
   input  logic [1:0]                i_rs2_bypass_en,
   input  exu_pkg::exu_word_t        i_rs1_bypass_data,
   input  exu_pkg::exu_word_t        i_rs2_bypass_data,
   input  exu_pkg::exu_word_t        i_gpr_rs1,
   input  exu_pkg::exu_word_t        i_gpr_rs2,
   input  logic                      i_rs1_en,
   input  logic                      i_rs2_en,
   input  logic                      i_select_pc,
   input  exu_pkg::exu_pc_t          i_pc_d,
   input  exu_pkg::exu_word_t        i_immed,
   input  logic [`EXU_BRIMM_W-1:0]   i_brimm,
   input  exu_pkg::exu_predict_pkt_t i_pp_d,
   input  logic                      i_flush_lower_r,     // Trap unit flush
   input  exu_pkg::exu_pc_t          i_flush_path_r,
   output exu_pkg::exu_word_t        o_result_x,
   output exu_pkg::exu_pc_t          o_pc_x,
   output logic                      o_flush_final,
   output exu_pkg::exu_pc_t          o_flush_path_final,
   output exu_pkg::exu_predict_pkt_t o_mp_pkt,
   output exu_pkg::exu_ghr_t         o_mp_fghr,
   output exu_pkg::exu_ghr_t         o_ghr_x
);

   import exu_pkg::*;

   exu_word_t rs1_d;
   exu_word_t rs2_d;
   exu_pc_t   flush_path_x;
   logic      flush_upper_x;
   logic      br_valid_d;
   logic      br_valid_x;
   logic      actual_taken_x;

   assign br_valid_d = i_pp_d.valid & i_alu_valid_d;

   exu_operand_sel i_operand_sel (
      .i_rs1_bypass_en   (i_rs1_bypass_en),
      .i_rs2_bypass_en   (i_rs2_bypass_en),
      .i_rs1_bypass_data (i_rs1_bypass_data),
      .i_rs2_bypass_data (i_rs2_bypass_data),
      .i_result_x        (o_result_x),                 // X result loops back
      .i_gpr_rs1         (i_gpr_rs1),
      .i_gpr_rs2         (i_gpr_rs2),
      .i_rs1_en          (i_rs1_en),
      .i_rs2_en          (i_rs2_en),
      .i_select_pc       (i_select_pc),
      .i_pc_d            (i_pc_d),
      .i_immed           (i_immed),
      .o_rs1             (rs1_d),
      .o_rs2             (rs2_d)
   );

   exu_alu i_alu (
      .clk              (clk),
      .i_rst            (i_rst),
      .i_x_ctl_en       (i_x_ctl_en),
      .i_valid_d        (i_alu_valid_d),
      .i_op             (i_op),
      .i_a              (rs1_d),
      .i_b              (rs2_d),
      .i_pc_d           (i_pc_d),
      .i_brimm          (i_brimm),
      .i_pp_d           (i_pp_d),
      .i_flush_lower_r  (i_flush_lower_r),
      .o_result_x       (o_result_x),
      .o_pc_x           (o_pc_x),
      .o_flush_upper_x  (flush_upper_x),
      .o_flush_path_x   (flush_path_x),
      .o_mp_pkt         (o_mp_pkt),
      .o_br_valid_x     (br_valid_x),
      .o_actual_taken_x (actual_taken_x)
   );

   exu_ghr i_ghr (
      .clk              (clk),
      .i_rst            (i_rst),
      .i_x_ctl_en       (i_x_ctl_en),
      .i_br_valid_d     (br_valid_d),
      .i_pred_taken_d   (i_pp_d.ataken),
      .i_br_valid_x     (br_valid_x),
      .i_actual_taken_x (actual_taken_x),
      .i_flush_upper_x  (flush_upper_x),
      .i_flush_lower_r  (i_flush_lower_r),
      .o_ghr_d          (),                            // D history stays internal
      .o_ghr_x          (o_ghr_x),
      .o_mp_fghr        (o_mp_fghr)
   );

   // Trap flush is the oldest source
   assign o_flush_final      = flush_upper_x | i_flush_lower_r;
   assign o_flush_path_final = i_flush_lower_r ? i_flush_path_r : flush_path_x;

endmodule

//--- source/exu_ghr.sv
`timescale 1ns/1ps
`include "exu_defines.svh"

module exu_ghr
(
   input  logic              clk,
   input  logic              i_rst,
   input  logic              i_x_ctl_en,
   input  logic              i_br_valid_d,         // Predicted branch at D
   input  logic              i_pred_taken_d,
   input  logic              i_br_valid_x,         // Predicted branch at X
   input  logic              i_actual_taken_x,
   input  logic              i_flush_upper_x,
   input  logic              i_flush_lower_r,
   output exu_pkg::exu_ghr_t o_ghr_d,              // Speculative history
   output exu_pkg::exu_ghr_t o_ghr_x,              // Resolved history
   output exu_pkg::exu_ghr_t o_mp_fghr
);

   import exu_pkg::*;

   exu_ghr_t ghr_d_ns;
   exu_ghr_t ghr_x_ns;

   always_comb
   begin
      if (i_flush_lower_r)
         ghr_d_ns = o_ghr_x;                       // Restore from resolved copy
      else if (i_br_valid_d)
         ghr_d_ns = {o_ghr_d[`EXU_GHR_SIZE-2:0], i_pred_taken_d};
      else
         ghr_d_ns = o_ghr_d;
   end

   assign ghr_x_ns = i_br_valid_x ? {o_ghr_x[`EXU_GHR_SIZE-2:0], i_actual_taken_x} : o_ghr_x;

   always_ff @(posedge clk)
   begin
      if (i_rst)
         o_ghr_d <= '0;
      else
         o_ghr_d <= ghr_d_ns;
   end

   always_ff @(posedge clk)
   begin
      if (i_rst)
         o_ghr_x <= '0;
      else if (i_x_ctl_en)
         o_ghr_x <= ghr_x_ns;
   end

   assign o_mp_fghr = (i_flush_upper_x & ~i_flush_lower_r) ? o_ghr_d : o_ghr_x;

endmodule

//--- source/exu_alu.sv
`timescale 1ns/1ps
`include "exu_defines.svh"

module exu_alu
(
   input  logic                      clk,
   input  logic                      i_rst,
   input  logic                      i_x_ctl_en,        // Advance D into X
   input  logic                      i_valid_d,
   input  exu_pkg::exu_alu_op_t      i_op,
   input  exu_pkg::exu_word_t        i_a,
   input  exu_pkg::exu_word_t        i_b,
   input  exu_pkg::exu_pc_t          i_pc_d,
   input  logic [`EXU_BRIMM_W-1:0]   i_brimm,           // Halfword offset
   input  exu_pkg::exu_predict_pkt_t i_pp_d,
   input  logic                      i_flush_lower_r,
   output exu_pkg::exu_word_t        o_result_x,
   output exu_pkg::exu_pc_t          o_pc_x,
   output logic                      o_flush_upper_x,
   output exu_pkg::exu_pc_t          o_flush_path_x,
   output exu_pkg::exu_predict_pkt_t o_mp_pkt,
   output logic                      o_br_valid_x,      // Predicted branch at X
   output logic                      o_actual_taken_x
);

   import exu_pkg::*;

   localparam int SHAMT_W = $clog2(`EXU_XLEN);
   localparam int SEXT_W  = $bits(exu_pc_t) - `EXU_BRIMM_W;

   logic                    valid_x;
   exu_alu_op_t             op_x;
   exu_predict_pkt_t        pp_x;
   exu_word_t               a_x;
   exu_word_t               b_x;
   exu_pc_t                 pc_x;
   logic [`EXU_BRIMM_W-1:0] brimm_x;

   exu_word_t               alu_val;
   logic                    is_br;
   logic                    cond;
   logic                    pred_taken;
   exu_pc_t                 pc_next;
   exu_pc_t                 pc_target;

   always_ff @(posedge clk)
   begin
      if (i_rst)
      begin
         valid_x <= 1'b0;
         op_x    <= op_add;
         pp_x    <= '0;
      end
      else if (i_x_ctl_en)
      begin
         valid_x <= i_valid_d & ~i_flush_lower_r;   // Killed by trap flush
         op_x    <= i_op;
         pp_x    <= i_pp_d;
      end
   end

   always_ff @(posedge clk)
   begin
      if (i_x_ctl_en)
      begin
         a_x     <= i_a;
         b_x     <= i_b;
         pc_x    <= i_pc_d;
         brimm_x <= i_brimm;
      end
   end

   always_comb
   begin
      case (op_x)
         op_sub:  alu_val = a_x - b_x;
         op_and:  alu_val = a_x & b_x;
         op_or:   alu_val = a_x | b_x;
         op_xor:  alu_val = a_x ^ b_x;
         op_slt:  alu_val = exu_word_t'($signed(a_x) < $signed(b_x));
         op_sltu: alu_val = exu_word_t'(a_x < b_x);
         op_sll:  alu_val = a_x << b_x[SHAMT_W-1:0];
         op_srl:  alu_val = a_x >> b_x[SHAMT_W-1:0];
         default: alu_val = a_x + b_x;
      endcase
   end

   always_comb
   begin
      is_br = 1'b1;
      case (op_x)
         br_beq:  cond = (a_x == b_x);
         br_bne:  cond = (a_x != b_x);
         br_blt:  cond = ($signed(a_x) < $signed(b_x));
         br_bge:  cond = ($signed(a_x) >= $signed(b_x));
         br_jal:  cond = 1'b1;
         default:
         begin
            is_br = 1'b0;
            cond  = 1'b0;
         end
      endcase
   end

   assign pc_next   = pc_x + exu_pc_t'(2);          // Sequential, 4 bytes on
   assign pc_target = pc_x + {{SEXT_W{brimm_x[`EXU_BRIMM_W-1]}}, brimm_x};

   always_comb
   begin
      if (!valid_x)
         o_result_x = '0;
      else if (op_x == br_jal)
         o_result_x = {pc_next, 1'b0};              // Link address
      else if (is_br)
         o_result_x = '0;
      else
         o_result_x = alu_val;
   end

   assign pred_taken       = pp_x.valid & pp_x.ataken;
   assign o_actual_taken_x = cond;
   assign o_br_valid_x     = valid_x & pp_x.valid;
   assign o_pc_x           = pc_x;

   // Direction mismatch, trap flush wins
   assign o_flush_upper_x  = valid_x & is_br & (cond ^ pred_taken) & ~i_flush_lower_r;
   assign o_flush_path_x   = cond ? pc_target : pc_next;

   always_comb
   begin
      o_mp_pkt = '0;
      if (o_flush_upper_x)
      begin
         o_mp_pkt      = pp_x;
         o_mp_pkt.misp = 1'b1;
      end
   end

endmodule

//--- source/exu_operand_sel.sv
`timescale 1ns/1ps
`include "exu_defines.svh"

module exu_operand_sel
(
   input  logic [1:0]         i_rs1_bypass_en,      // Bit 1 X result and bit 0 decode data
   input  logic [1:0]         i_rs2_bypass_en,      // Bit 1 X result and bit 0 decode data
   input  exu_pkg::exu_word_t i_rs1_bypass_data,
   input  exu_pkg::exu_word_t i_rs2_bypass_data,
   input  exu_pkg::exu_word_t i_result_x,           // Back-to-back bypass
   input  exu_pkg::exu_word_t i_gpr_rs1,
   input  exu_pkg::exu_word_t i_gpr_rs2,
   input  logic               i_rs1_en,             // Qualifies GPR rs1
   input  logic               i_rs2_en,             // Qualifies GPR rs2
   input  logic               i_select_pc,          // PC onto rs1 for jumps
   input  exu_pkg::exu_pc_t   i_pc_d,
   input  exu_pkg::exu_word_t i_immed,
   output exu_pkg::exu_word_t o_rs1,
   output exu_pkg::exu_word_t o_rs2
);

   import exu_pkg::*;

   logic      rs1_byp;
   logic      rs2_byp;
   exu_word_t rs1_byp_data;
   exu_word_t rs2_byp_data;

   assign rs1_byp = |i_rs1_bypass_en;
   assign rs2_byp = |i_rs2_bypass_en;

   // Decoder keeps the two select bits one-hot
   assign rs1_byp_data = ({`EXU_XLEN{i_rs1_bypass_en[0]}} & i_rs1_bypass_data) |
                         ({`EXU_XLEN{i_rs1_bypass_en[1]}} & i_result_x);

   assign rs2_byp_data = ({`EXU_XLEN{i_rs2_bypass_en[0]}} & i_rs2_bypass_data) |
                         ({`EXU_XLEN{i_rs2_bypass_en[1]}} & i_result_x);

   always_comb
   begin
      if (rs1_byp)
         o_rs1 = rs1_byp_data;
      else if (i_select_pc)
         o_rs1 = {i_pc_d, 1'b0};                    // Byte address of the jump
      else if (i_rs1_en)
         o_rs1 = i_gpr_rs1;
      else
         o_rs1 = '0;
   end

   always_comb
   begin
      if (rs2_byp)
         o_rs2 = rs2_byp_data;
      else if (i_rs2_en)
         o_rs2 = i_gpr_rs2;
      else
         o_rs2 = i_immed;                           // I-type and branch compare
   end

endmodule

//--- source/exu_pkg.sv
`include "exu_defines.svh"

package exu_pkg;

   typedef logic [`EXU_XLEN-1:0]     exu_word_t;
   typedef logic [`EXU_XLEN-1:1]     exu_pc_t;        // Halfword address
   typedef logic [`EXU_GHR_SIZE-1:0] exu_ghr_t;       // Newest direction in bit 0

   // ALU operations first, then branch kinds
   typedef enum logic [3:0] {
      op_add  = 4'd0,
      op_sub  = 4'd1,
      op_and  = 4'd2,
      op_or   = 4'd3,
      op_xor  = 4'd4,
      op_slt  = 4'd5,
      op_sltu = 4'd6,
      op_sll  = 4'd7,
      op_srl  = 4'd8,
      br_beq  = 4'd9,
      br_bne  = 4'd10,
      br_blt  = 4'd11,
      br_bge  = 4'd12,
      br_jal  = 4'd13
   } exu_alu_op_t;

   typedef struct packed {
      logic                    valid;                  // Predicted branch present
      logic                    ataken;                 // Predicted taken
      logic                    misp;                   // Mispredict, output copy only
      logic                    pc4;                    // 4-byte instruction
      logic [1:0]              hist;                   // Counter state
      logic [`EXU_BRIMM_W-1:0] toffset;                // Target offset
   } exu_predict_pkt_t;

endpackage

//--- source/exu_defines.svh
`ifndef EXU_DEFINES_SVH
`define EXU_DEFINES_SVH

// Data word width
`define EXU_XLEN 32

// Global branch history length
`define EXU_GHR_SIZE 8

// Branch offset in halfword units
`define EXU_BRIMM_W 12

`endif
